// ==== include/lsu_cfg.svh ====
// ==============================
// LSU subsystem sizing and timing
// ==============================
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// request FIFO entries, power of two only
`define LSU_FIFO_DEPTH 8

// data SRAM size in 32-bit words
`define SRAM_WORDS 256

// first byte address that answers SLVERR
`define SRAM_ERR_BASE (`SRAM_WORDS * 4)

// read pipeline depth inside the SRAM
`define SRAM_RD_LAT 1

`endif

// ==== hw/lsu_pkg.sv ====
// ==============================
// LSU enums, structs, bus types
// ==============================
package lsu_pkg;

    // memory op decoded by execute
    typedef enum logic [3:0] {
        OP_ALU = 4'd0,
        OP_LB  = 4'd1,
        OP_LH  = 4'd2,
        OP_LW  = 4'd3,
        OP_LBU = 4'd4,
        OP_LHU = 4'd5,
        OP_SB  = 4'd6,
        OP_SH  = 4'd7,
        OP_SW  = 4'd8
    } lsu_op_e;

    // controller FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ADDR = 2'd1,
        ST_RESP = 2'd2,
        ST_WB   = 2'd3
    } lsu_state_e;

    typedef struct packed {
        lsu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [4:0]  rd;
        logic        wen;
    } lsu_req_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] data;
        logic        err;
        logic        is_mem;
    } lsu_wb_t;

    // master side of the AXI-Lite link
    typedef struct packed {
        logic        ar_valid;
        logic [31:0] ar_addr;
        logic        aw_valid;
        logic [31:0] aw_addr;
        logic        w_valid;
        logic [31:0] w_data;
        logic [3:0]  w_strb;
        logic        r_ready;
        logic        b_ready;
    } axi_m2s_t;

    // slave side of the AXI-Lite link
    typedef struct packed {
        logic        ar_ready;
        logic        aw_ready;
        logic        w_ready;
        logic        r_valid;
        logic [31:0] r_data;
        logic [1:0]  r_resp;
        logic        b_valid;
        logic [1:0]  b_resp;
    } axi_s2m_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== hw/lsu_req_fifo.sv ====
// ==============================
// request FIFO, sticky overflow
// ==============================
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_req_fifo (
    input  logic              clk,
    input  logic              rst,
    input  logic              push_i,
    input  lsu_pkg::lsu_req_t push_data_i,
    input  logic              pop_i,
    output lsu_pkg::lsu_req_t head_o,
    output logic              empty_o,
    output logic              overflow_o
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(`LSU_FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(`LSU_FIFO_DEPTH);

    lsu_req_t         mem [`LSU_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == FULL_CNT);
    assign empty_o = (count == '0);
    // pop frees a slot in the same cycle
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full || do_pop);
    assign head_o  = mem[rd_ptr];

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            // pointers wrap on power-of-two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // dropped push latches the flag until reset
            if (push_i && !do_push) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/lsu_align.sv ====
// ==============================
// store lane shift, load extend
// ==============================
`timescale 1ns/10ps

module lsu_align (
    input  lsu_pkg::lsu_op_e op_i,
    input  logic [1:0]       addr_lo_i,
    input  logic [31:0]      st_data_i,
    input  logic [31:0]      rd_word_i,
    output logic [31:0]      st_data_o,
    output logic [3:0]       st_strb_o,
    output logic [31:0]      ld_data_o
);
    import lsu_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // lane select for loads
    assign ld_byte = rd_word_i[8*addr_lo_i +: 8];
    assign ld_half = addr_lo_i[1] ? rd_word_i[31:16] : rd_word_i[15:0];

    // store side
    always_comb begin
        st_data_o = st_data_i;
        st_strb_o = 4'b0000;
        case (op_i)
            OP_SB: begin
                // replicate byte, strobe picks the lane
                st_data_o = {4{st_data_i[7:0]}};
                st_strb_o = 4'b0001 << addr_lo_i;
            end
            OP_SH: begin
                st_data_o = {2{st_data_i[15:0]}};
                st_strb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW: begin
                st_strb_o = 4'b1111;
            end
            default: begin
                st_strb_o = 4'b0000;
            end
        endcase
    end

    // load side
    always_comb begin
        case (op_i)
            OP_LB:   ld_data_o = {{24{ld_byte[7]}}, ld_byte};
            OP_LBU:  ld_data_o = {24'd0, ld_byte};
            OP_LH:   ld_data_o = {{16{ld_half[15]}}, ld_half};
            OP_LHU:  ld_data_o = {16'd0, ld_half};
            OP_LW:   ld_data_o = rd_word_i;
            default: ld_data_o = 32'd0;
        endcase
    end

endmodule

// ==== hw/lsu_ctrl.sv ====
// ==============================
// LSU controller FSM, AXI master
// ==============================
`timescale 1ns/10ps

module lsu_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              empty_i,
    input  lsu_pkg::lsu_req_t head_i,
    output logic              pop_o,
    output lsu_pkg::axi_m2s_t axi_o,
    input  lsu_pkg::axi_s2m_t axi_i,
    output logic              wb_valid_o,
    output lsu_pkg::lsu_wb_t  wb_o
);
    import lsu_pkg::*;

    lsu_state_e  state_q;
    lsu_state_e  state_d;
    lsu_req_t    req_q;
    lsu_wb_t     wb_q;
    logic        ar_valid_q;
    logic        aw_valid_q;
    logic        w_valid_q;
    logic        cur_load;
    logic        cur_store;
    logic        ar_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        r_hs;
    logic        b_hs;
    logic        aw_done;
    logic        w_done;
    logic [31:0] st_data;
    logic [3:0]  st_strb;
    logic [31:0] ld_data;

    function automatic logic is_load_op(lsu_op_e op);
        return (op == OP_LB) || (op == OP_LH) || (op == OP_LW) ||
               (op == OP_LBU) || (op == OP_LHU);
    endfunction

    function automatic logic is_store_op(lsu_op_e op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    assign pop_o     = (state_q == ST_IDLE) && !empty_i;
    assign cur_load  = is_load_op(req_q.op);
    assign cur_store = is_store_op(req_q.op);

    // channel handshakes
    assign ar_hs   = ar_valid_q && axi_i.ar_ready;
    assign aw_hs   = aw_valid_q && axi_i.aw_ready;
    assign w_hs    = w_valid_q && axi_i.w_ready;
    assign r_hs    = cur_load && axi_i.r_valid && axi_o.r_ready;
    assign b_hs    = cur_store && axi_i.b_valid && axi_o.b_ready;
    // aw and w may land in different cycles
    assign aw_done = !aw_valid_q || aw_hs;
    assign w_done  = !w_valid_q || w_hs;

    lsu_align u_align (
        .op_i      (req_q.op),
        .addr_lo_i (req_q.addr[1:0]),
        .st_data_i (req_q.wdata),
        .rd_word_i (axi_i.r_data),
        .st_data_o (st_data),
        .st_strb_o (st_strb),
        .ld_data_o (ld_data)
    );

    always_comb begin
        axi_o          = '0;
        axi_o.ar_valid = ar_valid_q;
        axi_o.ar_addr  = {req_q.addr[31:2], 2'b00};
        axi_o.aw_valid = aw_valid_q;
        axi_o.aw_addr  = {req_q.addr[31:2], 2'b00};
        axi_o.w_valid  = w_valid_q;
        axi_o.w_data   = st_data;
        axi_o.w_strb   = st_strb;
        // responses taken any cycle in ST_RESP
        axi_o.r_ready  = (state_q == ST_RESP);
        axi_o.b_ready  = (state_q == ST_RESP);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (!empty_i) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                // alu result bypasses the bus
                if (!cur_load && !cur_store) begin
                    state_d = ST_WB;
                end else if (cur_load && ar_hs) begin
                    state_d = ST_RESP;
                end else if (cur_store && aw_done && w_done) begin
                    state_d = ST_RESP;
                end
            end
            ST_RESP: begin
                if (r_hs || b_hs) begin
                    state_d = ST_WB;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            ar_valid_q <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (pop_o) begin
                // raise valids for the request class
                ar_valid_q <= is_load_op(head_i.op);
                aw_valid_q <= is_store_op(head_i.op);
                w_valid_q  <= is_store_op(head_i.op);
            end else begin
                if (ar_hs) begin
                    ar_valid_q <= 1'b0;
                end
                if (aw_hs) begin
                    aw_valid_q <= 1'b0;
                end
                if (w_hs) begin
                    w_valid_q <= 1'b0;
                end
            end
        end
    end

    // request and writeback payload
    always_ff @(posedge clk) begin
        if (pop_o) begin
            req_q       <= head_i;
            wb_q.rd     <= head_i.rd;
            // stores never write the register file
            wb_q.wen    <= head_i.wen && !is_store_op(head_i.op);
            wb_q.is_mem <= is_load_op(head_i.op) || is_store_op(head_i.op);
            wb_q.err    <= 1'b0;
            if (is_load_op(head_i.op) || is_store_op(head_i.op)) begin
                wb_q.data <= 32'd0;
            end else begin
                wb_q.data <= head_i.addr;
            end
        end
        if (r_hs) begin
            wb_q.err  <= (axi_i.r_resp != RESP_OKAY);
            wb_q.data <= (axi_i.r_resp != RESP_OKAY) ? 32'd0 : ld_data;
        end
        if (b_hs) begin
            wb_q.err <= (axi_i.b_resp != RESP_OKAY);
        end
    end

    assign wb_valid_o = (state_q == ST_WB);
    assign wb_o       = wb_q;

endmodule

// ==== hw/data_sram_axi.sv ====
// ==============================
// AXI-Lite data SRAM slave
// ==============================
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module data_sram_axi (
    input  logic              clk,
    input  logic              rst,
    input  lsu_pkg::axi_m2s_t axi_i,
    output lsu_pkg::axi_s2m_t axi_o
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int LAT_W = $clog2(`SRAM_RD_LAT + 1);

    logic [31:0]      mem [`SRAM_WORDS];
    logic             idle;
    logic             ar_acc;
    logic             wr_acc;
    logic             wr_ok;
    logic             rd_ok;
    logic             rd_busy;
    logic [LAT_W-1:0] rd_cnt;
    logic [31:0]      rd_addr_q;
    logic             r_valid_q;
    logic [31:0]      r_data_q;
    logic [1:0]       r_resp_q;
    logic             b_valid_q;
    logic [1:0]       b_resp_q;

    // one transaction in flight
    assign idle   = !rd_busy && !r_valid_q && !b_valid_q;
    assign ar_acc = idle && axi_i.ar_valid;
    // aw and w taken together, reads win a tie
    assign wr_acc = idle && !axi_i.ar_valid && axi_i.aw_valid && axi_i.w_valid;
    assign wr_ok  = (axi_i.aw_addr < `SRAM_ERR_BASE);
    assign rd_ok  = (rd_addr_q < `SRAM_ERR_BASE);

    always_comb begin
        axi_o          = '0;
        axi_o.ar_ready = idle;
        axi_o.aw_ready = wr_acc;
        axi_o.w_ready  = wr_acc;
        axi_o.r_valid  = r_valid_q;
        axi_o.r_data   = r_data_q;
        axi_o.r_resp   = r_resp_q;
        axi_o.b_valid  = b_valid_q;
        axi_o.b_resp   = b_resp_q;
    end

    // byte-strobed write, mapped range only
    always_ff @(posedge clk) begin
        if (wr_acc && wr_ok) begin
            for (int i = 0; i < 4; i++) begin
                if (axi_i.w_strb[i]) begin
                    mem[axi_i.aw_addr[IDX_W+1:2]][8*i +: 8] <= axi_i.w_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy   <= 1'b0;
            rd_cnt    <= '0;
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_acc) begin
                rd_busy <= 1'b1;
                rd_cnt  <= LAT_W'(`SRAM_RD_LAT - 1);
            end else if (rd_busy) begin
                // count down the read latency
                if (rd_cnt == '0) begin
                    rd_busy   <= 1'b0;
                    r_valid_q <= 1'b1;
                end else begin
                    rd_cnt <= rd_cnt - 1'b1;
                end
            end
            if (r_valid_q && axi_i.r_ready) begin
                r_valid_q <= 1'b0;
            end
            if (wr_acc) begin
                b_valid_q <= 1'b1;
            end else if (b_valid_q && axi_i.b_ready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (ar_acc) begin
            rd_addr_q <= axi_i.ar_addr;
        end
        if (rd_busy && rd_cnt == '0) begin
            r_data_q <= rd_ok ? mem[rd_addr_q[IDX_W+1:2]] : 32'd0;
            r_resp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_acc) begin
            b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// ==== hw/lsu_subsys_top.sv ====
// ==============================
// LSU subsystem top
// ==============================
`timescale 1ns/10ps

module lsu_subsys_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  lsu_pkg::lsu_req_t req_i,
    output logic              wb_valid_o,
    output lsu_pkg::lsu_wb_t  wb_o,
    output logic              overflow_o
);
    import lsu_pkg::*;

    logic     fifo_empty;
    lsu_req_t fifo_head;
    logic     pop;
    axi_m2s_t axi_m2s;
    axi_s2m_t axi_s2m;

    // execute strobes land here, never stalled
    lsu_req_fifo u_fifo (
        .clk         (clk),
        .rst         (rst),
        .push_i      (req_valid_i),
        .push_data_i (req_i),
        .pop_i       (pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .overflow_o  (overflow_o)
    );

    lsu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .empty_i    (fifo_empty),
        .head_i     (fifo_head),
        .pop_o      (pop),
        .axi_o      (axi_m2s),
        .axi_i      (axi_s2m),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

    data_sram_axi u_sram (
        .clk   (clk),
        .rst   (rst),
        .axi_i (axi_m2s),
        .axi_o (axi_s2m)
    );

endmodule

// ==== dv/tb_lsu.sv ====
// ==============================
// LSU subsystem testbench
// directed tests, byte memory model
// ==============================
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module tb_lsu;
    import lsu_pkg::*;

    localparam int          AW        = $clog2(`SRAM_WORDS * 4);
    localparam logic [31:0] MEM_BYTES = 32'(`SRAM_WORDS * 4);

    logic     clk;
    logic     rst;
    logic     req_valid;
    lsu_req_t req;
    logic     wb_valid;
    lsu_wb_t  wb;
    logic     overflow;

    // reference memory with one entry per byte
    logic [7:0] ref_mem [`SRAM_WORDS * 4];
    // writebacks from the monitor in arrival order
    lsu_wb_t    wb_seen [$];
    integer     seed;

    lsu_subsys_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .wb_valid_o  (wb_valid),
        .wb_o        (wb),
        .overflow_o  (overflow)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // wb is a one-cycle pulse sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            wb_seen.push_back(wb);
        end
    end

    task automatic check_wb(input lsu_wb_t got, input lsu_wb_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got rd=%0d wen=%0b data=%h err=%0b is_mem=%0b", $time,
                     what, got.rd, got.wen, got.data, got.err, got.is_mem);
            $display("ERROR at %0t: %s: exp rd=%0d wen=%0b data=%h err=%0b is_mem=%0b", $time,
                     what, exp.rd, exp.wen, exp.data, exp.err, exp.is_mem);
            $display("TESTBENCH FAILED");
            $fatal(1, "writeback mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got %b, expected %b", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic logic op_reads_mem(lsu_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic op_writes_mem(lsu_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic lsu_req_t make_req(lsu_op_e op, logic [31:0] addr, logic [31:0] wdata,
                                          logic [4:0] rd, logic wen);
        lsu_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        r.rd    = rd;
        r.wen   = wen;
        return r;
    endfunction

    // word-aligned byte address inside the SRAM
    function automatic logic [31:0] rand_word_addr();
        logic [31:0] idx;
        idx = $unsigned($random(seed)) % 32'(`SRAM_WORDS);
        return idx << 2;
    endfunction

    // little-endian lanes with the half picked by address bit 1
    function automatic logic [31:0] model_load(lsu_op_e op, logic [31:0] addr);
        logic [AW-1:0] a;
        logic [7:0]    b;
        logic [15:0]   h;
        logic [31:0]   w;
        a = addr[AW-1:0];
        b = ref_mem[a];
        h = {ref_mem[{a[AW-1:1], 1'b1}], ref_mem[{a[AW-1:1], 1'b0}]};
        w = {ref_mem[{a[AW-1:2], 2'd3}], ref_mem[{a[AW-1:2], 2'd2}],
             ref_mem[{a[AW-1:2], 2'd1}], ref_mem[{a[AW-1:2], 2'd0}]};
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            OP_LW:   return w;
            default: return 32'd0;
        endcase
    endfunction

    function automatic void model_store(lsu_op_e op, logic [31:0] addr, logic [31:0] data);
        logic [AW-1:0] a;
        a = addr[AW-1:0];
        case (op)
            OP_SB: begin
                ref_mem[a] = data[7:0];
            end
            OP_SH: begin
                ref_mem[{a[AW-1:1], 1'b0}] = data[7:0];
                ref_mem[{a[AW-1:1], 1'b1}] = data[15:8];
            end
            OP_SW: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{a[AW-1:2], 2'(i)}] = data[8*i +: 8];
                end
            end
            default: begin
            end
        endcase
    endfunction

    // expected writeback and model update in request order
    function automatic lsu_wb_t predict(lsu_req_t r);
        lsu_wb_t e;
        logic    mapped;
        mapped   = (r.addr < MEM_BYTES);
        e.rd     = r.rd;
        e.wen    = r.wen;
        e.data   = r.addr;
        e.err    = 1'b0;
        e.is_mem = 1'b0;
        if (op_reads_mem(r.op)) begin
            e.is_mem = 1'b1;
            e.err    = !mapped;
            e.data   = mapped ? model_load(r.op, r.addr) : 32'd0;
        end else if (op_writes_mem(r.op)) begin
            e.is_mem = 1'b1;
            e.wen    = 1'b0;
            e.data   = 32'd0;
            e.err    = !mapped;
            if (mapped) begin
                model_store(r.op, r.addr, r.wdata);
            end
        end
        return e;
    endfunction

    task automatic put_req(input lsu_req_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
    endtask

    task automatic idle_req();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_wb(output lsu_wb_t got, input string what);
        int n;
        n = 0;
        while (wb_seen.size() == 0 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (wb_seen.size() == 0) begin
            $display("no writeback arrived within 50 cycles for %s", what);
            $display("TESTBENCH FAILED");
            $fatal(1, "writeback timeout");
        end
        got = wb_seen.pop_front();
    endtask

    task automatic run_one(input lsu_req_t r, input string what);
        lsu_wb_t exp;
        lsu_wb_t got;
        exp = predict(r);
        put_req(r);
        idle_req();
        wait_wb(got, what);
        check_wb(got, exp, what);
    endtask

    task automatic test_reset_idle();
        repeat (10) begin
            @(negedge clk);
            check_flag(wb_valid, 1'b0, "wb_valid_o quiet after reset");
            check_flag(overflow, 1'b0, "overflow_o clear after reset");
        end
        run_one(make_req(OP_ALU, 32'h1234_5678, 32'hdead_beef, 5'd7, 1'b1), "alu pass");
        run_one(make_req(OP_ALU, 32'h8000_0003, 32'h0, 5'd31, 1'b0), "alu no wen");
    endtask

    task automatic test_word_rw();
        logic [31:0] addr;
        for (int i = 0; i < 16; i++) begin
            addr = rand_word_addr();
            // store carries wen but its writeback clears it
            run_one(make_req(OP_SW, addr, $random(seed), 5'($random(seed)), 1'b1), "sw");
            run_one(make_req(OP_LW, addr, 32'd0, 5'($random(seed)), 1'b1), "lw after sw");
        end
    endtask

    task automatic test_sub_word();
        lsu_op_e     st_ops [2] = '{OP_SB, OP_SH};
        lsu_op_e     ld_ops [5] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        logic [31:0] base;
        logic [31:0] addr;
        for (int lane = 0; lane < 4; lane++) begin
            foreach (st_ops[s]) begin
                base = rand_word_addr();
                addr = base + 32'(lane);
                // known background word first
                run_one(make_req(OP_SW, base, $random(seed), 5'd1, 1'b1), "sw background");
                run_one(make_req(st_ops[s], addr, $random(seed), 5'd2, 1'b1), "sub-word store");
                foreach (ld_ops[l]) begin
                    run_one(make_req(ld_ops[l], addr, 32'd0, 5'($random(seed)), 1'b1),
                            "sub-word load");
                end
            end
        end
    endtask

    task automatic test_bus_error();
        logic [31:0] ok_addr;
        logic [31:0] bad_addr;
        ok_addr  = rand_word_addr();
        // same low index bits as ok_addr so a leaked write would show
        bad_addr = ok_addr + MEM_BYTES;
        run_one(make_req(OP_SW, ok_addr, 32'hcafe_f00d, 5'd3, 1'b1), "sw mapped");
        run_one(make_req(OP_LW, bad_addr, 32'd0, 5'd4, 1'b1), "lw unmapped");
        run_one(make_req(OP_SW, bad_addr, 32'h5555_aaaa, 5'd5, 1'b1), "sw unmapped");
        run_one(make_req(OP_SB, bad_addr + 32'd1, 32'h77, 5'd6, 1'b1), "sb unmapped");
        run_one(make_req(OP_LBU, 32'hffff_fff1, 32'd0, 5'd8, 1'b1), "lbu top of space");
        run_one(make_req(OP_LW, ok_addr, 32'd0, 5'd9, 1'b1), "lw mapped unchanged");
    endtask

    task automatic test_burst();
        lsu_req_t    burst [8];
        lsu_wb_t     exp_q [$];
        lsu_wb_t     got;
        logic [31:0] a;
        a = rand_word_addr();
        burst[0] = make_req(OP_SW, a, $random(seed), 5'd10, 1'b1);
        burst[1] = make_req(OP_LW, a, 32'd0, 5'd11, 1'b1);
        burst[2] = make_req(OP_ALU, 32'h0bad_cafe, 32'd0, 5'd12, 1'b1);
        burst[3] = make_req(OP_SB, a + 32'd1, $random(seed), 5'd13, 1'b1);
        burst[4] = make_req(OP_LBU, a + 32'd1, 32'd0, 5'd14, 1'b1);
        burst[5] = make_req(OP_SH, a + 32'd2, $random(seed), 5'd15, 1'b1);
        burst[6] = make_req(OP_LH, a + 32'd2, 32'd0, 5'd16, 1'b1);
        burst[7] = make_req(OP_LW, a, 32'd0, 5'd17, 1'b0);
        // model follows program order like the DUT
        foreach (burst[i]) begin
            exp_q.push_back(predict(burst[i]));
            put_req(burst[i]);
        end
        idle_req();
        foreach (burst[i]) begin
            wait_wb(got, "burst");
            check_wb(got, exp_q.pop_front(), "burst in order");
        end
        @(negedge clk);
        check_flag(overflow, 1'b0, "overflow_o after 8-deep burst");
    endtask

    task automatic test_overflow();
        lsu_wb_t exp;
        lsu_wb_t got;
        int      seen;
        int      quiet;
        int      n;
        int      exp_idx;
        // 16 alu ops on consecutive cycles overrun the FIFO
        for (int i = 1; i <= 16; i++) begin
            put_req(make_req(OP_ALU, 32'h100 + 32'(i), 32'd0, 5'(i), 1'b1));
        end
        idle_req();
        @(negedge clk);
        check_flag(overflow, 1'b1, "overflow_o after 16-deep burst");
        seen    = 0;
        quiet   = 0;
        n       = 0;
        exp_idx = 1;
        while (quiet < 20 && n < 300) begin
            @(posedge clk);
            n++;
            if (wb_seen.size() != 0) begin
                got = wb_seen.pop_front();
                // only requests past the 8th can be dropped
                while (exp_idx > 8 && exp_idx < 16 && got.rd != 5'(exp_idx)) begin
                    exp_idx++;
                end
                exp = predict(make_req(OP_ALU, 32'h100 + 32'(exp_idx), 32'd0,
                                       5'(exp_idx), 1'b1));
                check_wb(got, exp, "overflow burst in order");
                exp_idx++;
                seen++;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (quiet < 20) begin
            $display("writebacks kept arriving after the overflow burst ended");
            $display("TESTBENCH FAILED");
            $fatal(1, "drain timeout");
        end
        check_flag(seen >= 8 && seen < 16, 1'b1, "overflow burst lost some requests");
        check_flag(overflow, 1'b1, "overflow_o stays set");
    endtask

    initial begin
        seed      = 32'ha85189b4;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_reset_idle();
        test_word_rw();
        test_sub_word();
        test_bus_error();
        test_burst();
        // overflow is sticky so this one runs last
        test_overflow();

        @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
hw/lsu_pkg.sv
hw/lsu_req_fifo.sv
hw/lsu_align.sv
hw/lsu_ctrl.sv
hw/data_sram_axi.sv
hw/lsu_subsys_top.sv
dv/tb_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LSU subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_lsu -f compile.f --Mdir obj_dir -o tb_lsu_sim

status=0
./obj_dir/tb_lsu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation did not run to completion"
    exit 1
fi
echo "simulation clean"
